// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f vlog.f --top-module tb_eeprom_master -o sim_tb > build.log 2>&1 &&
    ./obj_dir/sim_tb > sim.log 2>&1 ||
    { echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log && echo "simulation passed" ||
    { echo "simulation failed, see sim.log"; exit 1; }

// ==== source/eeprom_master.sv ====
`default_nettype none

module eeprom_master
(
    input  wire logic                    CLK,
    input  wire logic                    RESET,
    input  wire logic                    req_valid,
    input  wire eeprom_pkg::eeprom_req_t req,
    output logic                         busy,
    output logic                         done,
    output eeprom_pkg::eeprom_rsp_t      rsp,
    output logic                         scl,
    output logic                         sda_drive, // high pulls sda low
    input  wire logic                    sda_in
);

    logic                 cmd_valid;
    eeprom_pkg::bit_cmd_t cmd;
    logic                 rsp_valid;
    eeprom_pkg::bit_rsp_t brsp;

    eeprom_sequencer eeprom_sequencer_inst
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .req_valid (req_valid),
        .req       (req),
        .busy      (busy),
        .done      (done),
        .rsp       (rsp),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .rsp_valid (rsp_valid),
        .brsp      (brsp)
    );

    i2c_bit_engine i2c_bit_engine_inst
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .rsp_valid (rsp_valid),
        .brsp      (brsp),
        .scl       (scl),
        .sda_drive (sda_drive),
        .sda_in    (sda_in)
    );

endmodule

`default_nettype wire

// ==== source/eeprom_pkg.sv ====
`default_nettype none

package eeprom_pkg;

    // bus timing, in CLK cycles per quarter of an SCL period
    localparam int scl_quarter = 1;

    // fixed upper nibble of the control byte
    localparam logic [3:0] device_code = 4'b1010;

    localparam int addr_width = 11; // 2048 bytes

    typedef enum logic
    {
        op_write = 1'b0,
        op_read  = 1'b1
    } eeprom_op_e;

    // bit engine commands, start doubles as repeated start
    typedef enum logic [1:0]
    {
        bit_start = 2'd0,
        bit_stop  = 2'd1,
        bit_write = 2'd2,
        bit_read  = 2'd3
    } bit_kind_e;

    typedef struct packed
    {
        eeprom_op_e              op;
        logic [addr_width-1:0]   addr;    // upper 3 bits select the block
        logic [7:0]              wr_data;
    } eeprom_req_t;

    typedef struct packed
    {
        logic [7:0] rd_data;
        logic       nack;
    } eeprom_rsp_t;

    typedef struct packed
    {
        bit_kind_e  kind;
        logic [7:0] data;
        logic       master_nack; // ninth bit sent on a read
    } bit_cmd_t;

    typedef struct packed
    {
        logic [7:0] data;
        logic       slave_nack;
    } bit_rsp_t;

endpackage

`default_nettype wire

// ==== source/eeprom_sequencer.sv ====
`default_nettype none

module eeprom_sequencer
(
    input  wire logic                    CLK,
    input  wire logic                    RESET,
    input  wire logic                    req_valid,
    input  wire eeprom_pkg::eeprom_req_t req,
    output logic                         busy,
    output logic                         done,
    output eeprom_pkg::eeprom_rsp_t      rsp,
    output logic                         cmd_valid,
    output eeprom_pkg::bit_cmd_t         cmd,
    input  wire logic                    rsp_valid,
    input  wire eeprom_pkg::bit_rsp_t    brsp
);

    typedef enum logic [3:0]
    {
        st_idle,
        st_start,
        st_ctrl_wr,
        st_addr,
        st_data_wr,
        st_restart,
        st_ctrl_rd,
        st_data_rd,
        st_stop,
        st_finish
    } seq_state_e;

    seq_state_e              state;
    seq_state_e              nxt;
    eeprom_pkg::eeprom_req_t req_q;
    eeprom_pkg::bit_cmd_t    next_cmd;
    logic [2:0]              block;
    logic                    accept;
    logic                    slave_nack;
    logic                    issue;

    assign block  = req_q.addr[eeprom_pkg::addr_width-1 -: 3];
    assign accept = req_valid && (state == st_idle || state == st_finish);
    assign busy   = state != st_idle && state != st_finish;
    assign done   = state == st_finish;

    // only bytes sent by the master carry a slave ack
    assign slave_nack = rsp_valid && brsp.slave_nack &&
                        (state == st_ctrl_wr || state == st_addr ||
                         state == st_data_wr || state == st_ctrl_rd);

    assign issue = nxt != state && nxt != st_idle && nxt != st_finish;

    always_comb
    begin
        nxt = state;
        case (state)
            st_idle, st_finish:
                nxt = req_valid ? st_start : st_idle;
            st_start:
                if (rsp_valid) nxt = st_ctrl_wr;
            st_ctrl_wr:
                if (rsp_valid) nxt = slave_nack ? st_stop : st_addr;
            st_addr:
                if (rsp_valid)
                begin
                    if (slave_nack)
                        nxt = st_stop;
                    else if (req_q.op == eeprom_pkg::op_write)
                        nxt = st_data_wr;
                    else
                        nxt = st_restart;
                end
            st_data_wr:
                if (rsp_valid) nxt = st_stop; // nack or not, stop next
            st_restart:
                if (rsp_valid) nxt = st_ctrl_rd;
            st_ctrl_rd:
                if (rsp_valid) nxt = slave_nack ? st_stop : st_data_rd;
            st_data_rd:
                if (rsp_valid) nxt = st_stop;
            st_stop:
                if (rsp_valid) nxt = st_finish;
            default:
                nxt = st_idle;
        endcase
    end

    // command for the state being entered
    always_comb
    begin
        next_cmd.kind        = eeprom_pkg::bit_write;
        next_cmd.data        = req_q.wr_data;
        next_cmd.master_nack = 1'b1; // single byte read ends with nack
        case (nxt)
            st_start, st_restart:
                next_cmd.kind = eeprom_pkg::bit_start;
            st_ctrl_wr:
                next_cmd.data = {eeprom_pkg::device_code, block, 1'b0};
            st_addr:
                next_cmd.data = req_q.addr[7:0];
            st_ctrl_rd:
                next_cmd.data = {eeprom_pkg::device_code, block, 1'b1};
            st_data_rd:
                next_cmd.kind = eeprom_pkg::bit_read;
            st_stop:
                next_cmd.kind = eeprom_pkg::bit_stop;
            default:
            begin
            end
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= st_idle;
            cmd_valid <= 1'b0;
        end
        else
        begin
            state     <= nxt;
            cmd_valid <= issue;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
            req_q <= req;
        if (issue)
            cmd <= next_cmd;
        if (accept)
        begin
            rsp <= '0;
        end
        else
        begin
            if (slave_nack)
                rsp.nack <= 1'b1;
            if (rsp_valid && state == st_data_rd)
                rsp.rd_data <= brsp.data;
        end
    end

endmodule

`default_nettype wire

// ==== source/i2c_bit_engine.sv ====
`default_nettype none

module i2c_bit_engine
(
    input  wire logic                 CLK,
    input  wire logic                 RESET,
    input  wire logic                 cmd_valid,
    input  wire eeprom_pkg::bit_cmd_t cmd,
    output logic                      rsp_valid,
    output eeprom_pkg::bit_rsp_t      brsp,
    output logic                      scl,
    output logic                      sda_drive,
    input  wire logic                 sda_in
);

    logic                  active;
    logic [1:0]            phase;     // low-early, low-late, high-early, high-late
    logic [7:0]            q_cnt;
    logic [3:0]            bit_cnt;   // 0..8, slot 8 is the ack bit
    eeprom_pkg::bit_kind_e kind_q;
    logic                  mnack_q;
    logic [7:0]            sreg;
    logic                  nack_q;
    logic                  accept;
    logic                  q_end;
    logic                  step;
    logic                  is_frame;
    logic                  last_bit;
    logic                  low_drive;

    assign accept   = cmd_valid && !active;
    assign q_end    = q_cnt == 8'(eeprom_pkg::scl_quarter - 1);
    assign step     = active && q_end;
    assign is_frame = kind_q == eeprom_pkg::bit_start || kind_q == eeprom_pkg::bit_stop;
    assign last_bit = is_frame || bit_cnt == 4'd8;

    assign rsp_valid       = step && phase == 2'd3 && last_bit;
    assign brsp.data       = sreg;
    assign brsp.slave_nack = nack_q;

    // idle bus keeps scl high
    assign scl = !active || phase[1];

    // sda value taken on entry to the low-late quarter
    always_comb
    begin
        case (kind_q)
            eeprom_pkg::bit_start:
                low_drive = 1'b0; // release so sda is high before scl rises
            eeprom_pkg::bit_stop:
                low_drive = 1'b1;
            eeprom_pkg::bit_write:
                low_drive = (bit_cnt == 4'd8) ? 1'b0 : !sreg[7];
            default:
                low_drive = (bit_cnt == 4'd8) ? !mnack_q : 1'b0;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active    <= 1'b0;
            phase     <= 2'd0;
            q_cnt     <= 8'd0;
            bit_cnt   <= 4'd0;
            sda_drive <= 1'b0;
        end
        else if (accept)
        begin
            active  <= 1'b1;
            phase   <= 2'd0;
            q_cnt   <= 8'd0;
            bit_cnt <= 4'd0;
        end
        else if (active)
        begin
            if (!q_end)
            begin
                q_cnt <= q_cnt + 8'd1;
            end
            else
            begin
                q_cnt <= 8'd0;
                phase <= phase + 2'd1;
                case (phase)
                    2'd0:
                        sda_drive <= low_drive;
                    2'd2:
                    begin
                        // start and stop edges while scl is high
                        if (kind_q == eeprom_pkg::bit_start)
                            sda_drive <= 1'b1;
                        else if (kind_q == eeprom_pkg::bit_stop)
                            sda_drive <= 1'b0;
                    end
                    2'd3:
                    begin
                        if (last_bit)
                            active <= 1'b0;
                        else
                            bit_cnt <= bit_cnt + 4'd1;
                    end
                    default:
                    begin
                    end
                endcase
            end
        end
    end

    // shift register and sampled ack, sampled mid high phase
    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            kind_q  <= cmd.kind;
            mnack_q <= cmd.master_nack;
            sreg    <= cmd.data;
        end
        else if (step && phase == 2'd2 && !is_frame)
        begin
            if (bit_cnt == 4'd8)
                nack_q <= sda_in;
            else
                sreg <= {sreg[6:0], sda_in}; // msb first
        end
    end

endmodule

`default_nettype wire

// ==== testbench/eeprom_checker.sv ====
`default_nettype none

module eeprom_checker
#(
    parameter logic [7:0] fill_key = 8'h00
)
(
    input  wire logic                    CLK,
    input  wire logic                    RESET,
    input  wire logic                    req_valid,
    input  wire eeprom_pkg::eeprom_req_t req,
    input  wire logic                    busy,
    input  wire logic                    done,
    input  wire eeprom_pkg::eeprom_rsp_t rsp,
    input  wire logic                    scl,
    input  wire logic                    sda_drive,
    input  wire logic                    refuse,
    output int                           errors,
    output int                           done_count
);

    logic [7:0]              shadow [0:2047];
    eeprom_pkg::eeprom_req_t pend_q [$];
    logic                    refuse_q [$];  // refuse at acceptance predicts nack
    logic                    rst_q = 1'b0;
    int                      err_cnt = 0;
    int                      done_cnt = 0;

    assign errors     = err_cnt;
    assign done_count = done_cnt;

    initial
    begin
        for (int a = 0; a < 2048; a++)
            shadow[11'(a)] = 8'(a * 37) ^ {3'(a >> 8), 5'd0} ^ fill_key;
    end

    always @(posedge CLK)
    begin
        eeprom_pkg::eeprom_req_t cur;
        logic                    cur_refuse;
        logic                    exp_busy;
        // outputs of the cycle that followed a reset edge
        if (rst_q)
        begin
            if (scl !== 1'b1)
            begin
                $display("Error: scl = %h in reset, expected %h", scl, 1'b1);
                err_cnt++;
            end
            if (sda_drive !== 1'b0 || busy !== 1'b0 || done !== 1'b0)
            begin
                $display("Error: sda_drive/busy/done = %h/%h/%h in reset, expected 0/0/0",
                         sda_drive, busy, done);
                err_cnt++;
            end
        end
        rst_q <= RESET;
        if (!RESET && done)
        begin
            done_cnt++;
            if (pend_q.size() == 0)
            begin
                $display("done strobe arrived with no request pending");
                err_cnt++;
            end
            else
            begin
                cur        = pend_q.pop_front();
                cur_refuse = refuse_q.pop_front();
                if (rsp.nack !== cur_refuse)
                begin
                    $display("Error: rsp.nack = %h, expected %h (addr %h)",
                             rsp.nack, cur_refuse, cur.addr);
                    err_cnt++;
                end
                if (cur.op == eeprom_pkg::op_read && !cur_refuse &&
                    rsp.rd_data !== shadow[cur.addr])
                begin
                    $display("Error: rsp.rd_data = %h, expected %h (addr %h)",
                             rsp.rd_data, shadow[cur.addr], cur.addr);
                    err_cnt++;
                end
                if (cur.op == eeprom_pkg::op_write && !cur_refuse)
                    shadow[cur.addr] = cur.wr_data;
            end
        end
        if (!RESET)
        begin
            // busy from the cycle after acceptance up to the done strobe
            exp_busy = pend_q.size() != 0;
            if (busy !== exp_busy)
            begin
                $display("Error: busy = %h, expected %h", busy, exp_busy);
                err_cnt++;
            end
            if (req_valid && !exp_busy)
            begin
                pend_q.push_back(req);
                refuse_q.push_back(refuse);
            end
        end
    end

endmodule

`default_nettype wire

// ==== testbench/eeprom_slave_model.sv ====
`default_nettype none

module eeprom_slave_model
#(
    parameter logic [7:0] fill_key = 8'h00
)
(
    input  wire logic CLK,
    input  wire logic scl,
    input  wire logic sda,
    input  wire logic refuse,   // withhold every acknowledge while high
    output logic      sda_pull
);

    typedef enum logic [2:0]
    {
        s_idle,
        s_rx,
        s_ack,
        s_ack_hold,
        s_tx,
        s_mack
    } slave_state_e;

    typedef enum logic [1:0]
    {
        b_ctrl,
        b_addr,
        b_data
    } byte_kind_e;

    logic [7:0]   mem [0:2047];
    slave_state_e state = s_idle;
    byte_kind_e   kind = b_ctrl;
    logic         scl_q = 1'b1;
    logic         sda_q = 1'b1;
    logic         pull = 1'b0;
    logic [3:0]   bit_cnt = 4'd0;
    logic [7:0]   shift = 8'd0;
    logic [7:0]   tx_byte = 8'd0;
    logic [2:0]   block = 3'd0;
    logic [7:0]   word = 8'd0;   // address counter, kept across a repeated start
    logic         ack_ok = 1'b0;
    logic         read_mode = 1'b0;
    logic [7:0]   rx_byte;

    assign sda_pull = pull;
    assign rx_byte  = {shift[6:0], sda};

    initial
    begin
        for (int a = 0; a < 2048; a++)
            mem[11'(a)] = 8'(a * 37) ^ {3'(a >> 8), 5'd0} ^ fill_key;
    end

    always @(posedge CLK)
    begin
        scl_q <= scl;
        sda_q <= sda;
        if (scl && scl_q && sda_q && !sda)
        begin
            // start or repeated start, drops any half received byte
            state   <= s_rx;
            kind    <= b_ctrl;
            bit_cnt <= 4'd0;
            pull    <= 1'b0;
        end
        else if (scl && scl_q && !sda_q && sda)
        begin
            state <= s_idle; // stop
            pull  <= 1'b0;
        end
        else if (scl && !scl_q)
        begin
            case (state)
                s_rx:
                begin
                    shift   <= rx_byte;
                    bit_cnt <= bit_cnt + 4'd1;
                    if (bit_cnt == 4'd7)
                    begin
                        state <= s_ack;
                        case (kind)
                            b_ctrl:
                            begin
                                ack_ok    <= rx_byte[7:4] == eeprom_pkg::device_code && !refuse;
                                block     <= rx_byte[3:1];
                                read_mode <= rx_byte[0];
                                tx_byte   <= mem[{rx_byte[3:1], word}];
                                kind      <= b_addr;
                            end
                            b_addr:
                            begin
                                ack_ok <= !refuse;
                                word   <= rx_byte;
                                kind   <= b_data;
                            end
                            default:
                            begin
                                ack_ok <= !refuse;
                                if (!refuse)
                                    mem[{block, word}] <= rx_byte;
                            end
                        endcase
                    end
                end
                s_tx:
                begin
                    bit_cnt <= bit_cnt + 4'd1;
                    if (bit_cnt == 4'd7)
                        state <= s_mack;
                end
                s_mack:
                    state <= s_idle; // master always answers the single byte with nack
                default:
                begin
                end
            endcase
        end
        else if (!scl && scl_q)
        begin
            case (state)
                s_ack:
                begin
                    pull  <= ack_ok;
                    state <= s_ack_hold;
                end
                s_ack_hold:
                begin
                    bit_cnt <= 4'd0;
                    if (!ack_ok)
                    begin
                        pull  <= 1'b0;
                        state <= s_idle;
                    end
                    else if (read_mode)
                    begin
                        pull  <= !tx_byte[7];
                        state <= s_tx;
                    end
                    else
                    begin
                        pull  <= 1'b0;
                        state <= s_rx;
                    end
                end
                s_tx:
                    pull <= !tx_byte[3'(4'd7 - bit_cnt)]; // msb first
                s_mack:
                    pull <= 1'b0;
                default:
                begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_eeprom_master.sv ====
`default_nettype none

module tb_eeprom_master;

    localparam int         num_pairs   = 40;
    localparam int         num_fresh   = 24;
    localparam int         num_refused = 4;
    localparam int         total_reqs  = 2 * num_pairs + num_fresh + 2 * num_refused + 3;
    localparam int         cycle_limit = total_reqs * 300 * eeprom_pkg::scl_quarter;
    localparam logic [7:0] fill_key    = 8'h5c;

    logic                    CLK;
    logic                    RESET;
    logic                    req_valid;
    eeprom_pkg::eeprom_req_t req;
    logic                    busy;
    logic                    done;
    eeprom_pkg::eeprom_rsp_t rsp;
    logic                    scl;
    logic                    sda_drive;
    logic                    slave_pull;
    logic                    refuse;
    wire logic               sda;
    int                      check_errors;
    int                      done_count;
    int                      passed_tests = 0;
    int                      failed_tests = 0;
    int                      cycle_cnt = 0;
    bit                      written [0:2047];
    logic [10:0]             wr_addrs [$];

    assign sda = !(sda_drive || slave_pull); // wired-AND, either side pulls low

    eeprom_master eeprom_master_inst
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .req_valid (req_valid),
        .req       (req),
        .busy      (busy),
        .done      (done),
        .rsp       (rsp),
        .scl       (scl),
        .sda_drive (sda_drive),
        .sda_in    (sda)
    );

    eeprom_slave_model #(.fill_key(fill_key)) eeprom_slave_model_inst
    (
        .CLK      (CLK),
        .scl      (scl),
        .sda      (sda),
        .refuse   (refuse),
        .sda_pull (slave_pull)
    );

    eeprom_checker #(.fill_key(fill_key)) eeprom_checker_inst
    (
        .CLK        (CLK),
        .RESET      (RESET),
        .req_valid  (req_valid),
        .req        (req),
        .busy       (busy),
        .done       (done),
        .rsp        (rsp),
        .scl        (scl),
        .sda_drive  (sda_drive),
        .refuse     (refuse),
        .errors     (check_errors),
        .done_count (done_count)
    );

    initial
    begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    initial
    begin
        while (cycle_cnt < cycle_limit)
        begin
            @(posedge CLK);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, a done strobe never came", cycle_limit);
        $display("SOME TESTS FAILED");
        $finish;
    end

    task automatic send_req(input eeprom_pkg::eeprom_op_e op, input logic [10:0] addr,
                            input logic [7:0] data);
        @(negedge CLK);
        req_valid   = 1'b1;
        req.op      = op;
        req.addr    = addr;
        req.wr_data = data;
        @(negedge CLK);
        req_valid = 1'b0;
    endtask

    task automatic wait_done();
        while (!done)
            @(negedge CLK);
        @(negedge CLK); // checker compares on the edge after done
    endtask

    task automatic run_request(input eeprom_pkg::eeprom_op_e op, input logic [10:0] addr,
                               input logic [7:0] data);
        send_req(op, addr, data);
        wait_done();
    endtask

    task automatic close_test(input string name, input int errs_before, input bit extra_ok);
        int n;
        n = check_errors - errs_before;
        if (n == 0 && extra_ok)
        begin
            passed_tests++;
            $display("test %s: ok", name);
        end
        else
        begin
            failed_tests++;
            $display("test %s: failed, %0d checker errors", name, n);
        end
    endtask

    initial
    begin
        int          seed_init;
        int          errs_before;
        int          dones_before;
        logic [10:0] addr;
        logic [7:0]  data;
        seed_init = $urandom(98497);
        RESET     = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        refuse    = 1'b0;
        repeat (4) @(negedge CLK);
        RESET = 1'b0;
        repeat (2) @(negedge CLK);
        close_test("reset state", 0, 1'b1);

        errs_before = check_errors;
        for (int i = 0; i < num_pairs; i++)
        begin
            addr = 11'($urandom);
            data = 8'($urandom);
            run_request(eeprom_pkg::op_write, addr, data);
            run_request(eeprom_pkg::op_read, addr, 8'd0);
            written[addr] = 1'b1;
            wr_addrs.push_back(addr);
        end
        close_test("read-back", errs_before, 1'b1);

        errs_before = check_errors;
        for (int i = 0; i < num_fresh; i++)
        begin
            addr = {3'(i), 8'($urandom)}; // walks all eight blocks
            while (written[addr])
                addr[7:0] = 8'($urandom);
            run_request(eeprom_pkg::op_read, addr, 8'd0);
        end
        close_test("uninitialized read", errs_before, 1'b1);

        errs_before = check_errors;
        for (int i = 0; i < num_refused; i++)
        begin
            addr   = wr_addrs[i * 9];
            refuse = 1'b1;
            run_request(eeprom_pkg::op_write, addr, 8'($urandom));
            refuse = 1'b0;
            run_request(eeprom_pkg::op_read, addr, 8'd0);
        end
        close_test("refused write", errs_before, 1'b1);

        errs_before  = check_errors;
        dones_before = done_count;
        addr = 11'($urandom);
        data = 8'($urandom);
        send_req(eeprom_pkg::op_write, addr, data);
        req_valid   = 1'b1; // busy is already high, same address with other data
        req.wr_data = ~data;
        @(negedge CLK);
        req_valid = 1'b0;
        wait_done();
        repeat (150) @(negedge CLK);
        run_request(eeprom_pkg::op_read, addr, 8'd0);
        if (done_count - dones_before != 2)
            $display("expected 2 done strobes for the write and the read, saw %0d",
                     done_count - dones_before);
        close_test("dropped request", errs_before, done_count - dones_before == 2);

        $display("summary: %0d tests passed, %0d failed, %0d checker errors, %0d done strobes",
                 passed_tests, failed_tests, check_errors, done_count);
        if (failed_tests == 0 && check_errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
source/eeprom_pkg.sv
source/i2c_bit_engine.sv
source/eeprom_sequencer.sv
source/eeprom_master.sv
testbench/eeprom_slave_model.sv
testbench/eeprom_checker.sv
testbench/tb_eeprom_master.sv
